// ==== Makefile ====
VERILATOR = verilator
VFLAGS    = --binary --timing --assert --timescale 1ns/1ps -j 0
TOP       = tb_llc_tag_store
FILELIST  = build.f

.PHONY: sim clean

# Build, run, and pass only when the pass line shows up in the output
sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST)
	@out="$$(./obj_dir/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "NO ERRORS"

clean:
	rm -rf obj_dir

// ==== build.f ====
hdl/llc_tag_pkg.sv
hdl/tag_way_array.sv
hdl/victim_picker.sv
hdl/tag_store_ctrl.sv
hdl/llc_tag_store.sv
testbench/tb_llc_tag_store_asserts.sv
testbench/tb_llc_tag_store.sv

// ==== hdl/llc_tag_pkg.sv ====
package llc_tag_pkg;

  // --------------------------------------------------------------------------
  // Cache geometry
  // --------------------------------------------------------------------------

  // Set associativity of the tag store
  localparam int unsigned NUM_WAYS = 4;

  // Set index width, 64 sets
  localparam int unsigned INDEX_BITS = 6;

  // Number of sets, one entry per set in every way
  localparam int unsigned NUM_SETS = 1 << INDEX_BITS;

  // Stored tag width
  localparam int unsigned TAG_BITS = 10;

  // Binary way number width
  localparam int unsigned WAY_SEL_BITS = 2;

  // --------------------------------------------------------------------------
  // Vector types
  // --------------------------------------------------------------------------

  // One bit per way
  // Used for one-hot selects, lock masks and hit vectors
  typedef logic [NUM_WAYS-1:0] way_ind_t;

  // Binary way number
  typedef logic [WAY_SEL_BITS-1:0] way_sel_t;

  // Set index, doubles as the storage address
  typedef logic [INDEX_BITS-1:0] index_t;

  // Tag as kept in the storage
  typedef logic [TAG_BITS-1:0] tag_t;

  // --------------------------------------------------------------------------
  // Request modes
  // --------------------------------------------------------------------------

  // Lookup compares against all unlocked ways, flush targets one way
  typedef enum logic [0:0] {
    OP_LOOKUP = 1'b0,
    OP_FLUSH  = 1'b1
  } tag_op_e;

endpackage

// ==== hdl/llc_tag_store.sv ====
`timescale 1ns/1ps

module llc_tag_store (
  input  logic                  clk_i,
  input  logic                  reset_i,
  // Request side
  input  logic                  req_valid_i,
  output logic                  req_ready_o,
  input  llc_tag_pkg::tag_op_e  req_op_i,
  input  llc_tag_pkg::index_t   req_index_i,
  input  llc_tag_pkg::tag_t     req_tag_i,
  input  logic                  req_dirty_i,
  input  llc_tag_pkg::way_ind_t req_way_i,
  // Scratchpad lock per way
  input  llc_tag_pkg::way_ind_t spm_lock_i,
  // Response side
  output logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  output llc_tag_pkg::way_ind_t rsp_way_o,
  output logic                  rsp_hit_o,
  output logic                  rsp_evict_o,
  output llc_tag_pkg::tag_t     rsp_evict_tag_o
);

  import llc_tag_pkg::*;

  // Controller to array
  logic     rd_en;
  logic     wr_en;
  way_ind_t wr_way;
  index_t   index;
  tag_t     cmp_tag;
  tag_t     wr_tag;
  logic     wr_valid;
  logic     wr_dirty;

  // Array read data
  way_ind_t                  way_valid;
  way_ind_t                  way_dirty;
  way_ind_t                  way_match;
  tag_t [NUM_WAYS-1:0]       way_tags;

  // Victim picker results
  way_ind_t victim;
  logic     victim_evict;
  tag_t     victim_tag;
  logic     victim_take;

  // --------------------------------------------------------------------------
  // Storage and replacement side by side
  // --------------------------------------------------------------------------

  tag_way_array u_ways (
    .clk_i      (clk_i),
    .reset_i    (reset_i),
    .rd_en_i    (rd_en),
    .wr_en_i    (wr_en),
    .wr_way_i   (wr_way),
    .index_i    (index),
    .cmp_tag_i  (cmp_tag),
    .wr_tag_i   (wr_tag),
    .wr_valid_i (wr_valid),
    .wr_dirty_i (wr_dirty),
    .valid_o    (way_valid),
    .dirty_o    (way_dirty),
    .match_o    (way_match),
    .tags_o     (way_tags)
  );

  victim_picker u_victim (
    .clk_i       (clk_i),
    .reset_i     (reset_i),
    .valid_i     (way_valid),
    .dirty_i     (way_dirty),
    .lock_i      (spm_lock_i),
    .tags_i      (way_tags),
    .take_i      (victim_take),
    .victim_o    (victim),
    .evict_o     (victim_evict),
    .evict_tag_o (victim_tag)
  );

  // Merges both into the response
  tag_store_ctrl u_ctrl (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .req_way_i       (req_way_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_way_o       (rsp_way_o),
    .rsp_hit_o       (rsp_hit_o),
    .rsp_evict_o     (rsp_evict_o),
    .rsp_evict_tag_o (rsp_evict_tag_o),
    .spm_lock_i      (spm_lock_i),
    .rd_en_o         (rd_en),
    .wr_en_o         (wr_en),
    .wr_way_o        (wr_way),
    .index_o         (index),
    .cmp_tag_o       (cmp_tag),
    .wr_tag_o        (wr_tag),
    .wr_valid_o      (wr_valid),
    .wr_dirty_o      (wr_dirty),
    .valid_i         (way_valid),
    .dirty_i         (way_dirty),
    .match_i         (way_match),
    .tags_i          (way_tags),
    .victim_i        (victim),
    .victim_evict_i  (victim_evict),
    .victim_tag_i    (victim_tag),
    .take_o          (victim_take)
  );

endmodule

// ==== hdl/tag_store_ctrl.sv ====
`timescale 1ns/1ps

module tag_store_ctrl (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  // Request side
  input  logic                                                req_valid_i,
  output logic                                                req_ready_o,
  input  llc_tag_pkg::tag_op_e                                req_op_i,
  input  llc_tag_pkg::index_t                                 req_index_i,
  input  llc_tag_pkg::tag_t                                   req_tag_i,
  input  logic                                                req_dirty_i,
  input  llc_tag_pkg::way_ind_t                               req_way_i,
  // Response side
  output logic                                                rsp_valid_o,
  input  logic                                                rsp_ready_i,
  output llc_tag_pkg::way_ind_t                               rsp_way_o,
  output logic                                                rsp_hit_o,
  output logic                                                rsp_evict_o,
  output llc_tag_pkg::tag_t                                   rsp_evict_tag_o,
  input  llc_tag_pkg::way_ind_t                               spm_lock_i,
  // Way array
  output logic                                                rd_en_o,
  output logic                                                wr_en_o,
  output llc_tag_pkg::way_ind_t                               wr_way_o,
  output llc_tag_pkg::index_t                                 index_o,
  output llc_tag_pkg::tag_t                                   cmp_tag_o,
  output llc_tag_pkg::tag_t                                   wr_tag_o,
  output logic                                                wr_valid_o,
  output logic                                                wr_dirty_o,
  input  llc_tag_pkg::way_ind_t                               valid_i,
  input  llc_tag_pkg::way_ind_t                               dirty_i,
  input  llc_tag_pkg::way_ind_t                               match_i,
  input  llc_tag_pkg::tag_t [llc_tag_pkg::NUM_WAYS-1:0]       tags_i,
  // Victim picker
  input  llc_tag_pkg::way_ind_t                               victim_i,
  input  logic                                                victim_evict_i,
  input  llc_tag_pkg::tag_t                                   victim_tag_i,
  output logic                                                take_o
);

  import llc_tag_pkg::*;

  typedef enum logic {
    IDLE,
    RESPOND
  } state_e;

  state_e state_q, state_d;

  // Latched request
  tag_op_e  op_q;
  index_t   index_q;
  tag_t     tag_q;
  logic     dirty_q;
  way_ind_t way_q;

  // Lookup results
  way_ind_t hit_vec;
  logic     is_hit;
  logic     hit_dirty;
  // Flush results
  tag_t     flush_tag;
  logic     flush_evict;
  logic     rsp_fire;

  // Hits only on valid, unlocked ways
  assign hit_vec   = match_i & valid_i & ~spm_lock_i;
  assign is_hit    = |hit_vec;
  assign hit_dirty = |(hit_vec & dirty_i);

  // Tag of the flushed way, way_q is one-hot
  always_comb begin : proc_flush_tag
    flush_tag = '0;
    for (int w = 0; w < NUM_WAYS; w++) begin
      if (way_q[w]) begin
        flush_tag = flush_tag | tags_i[w];
      end
    end
  end

  assign flush_evict = |(way_q & valid_i & dirty_i);

  // --------------------------------------------------------------------------
  // Request sequencing
  // --------------------------------------------------------------------------

  assign req_ready_o = (state_q == IDLE);
  assign rsp_valid_o = (state_q == RESPOND);
  assign rsp_fire    = rsp_valid_o & rsp_ready_i;

  // Storage read starts on the accepting edge
  assign rd_en_o   = req_ready_o & req_valid_i;
  assign index_o   = req_ready_o ? req_index_i : index_q;
  assign cmp_tag_o = req_tag_i;

  always_comb begin : proc_next
    state_d = state_q;
    unique case (state_q)
      IDLE:    if (req_valid_i) state_d = RESPOND;
      RESPOND: if (rsp_ready_i) state_d = IDLE;
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      state_q <= IDLE;
    end else begin
      state_q <= state_d;
    end
  end

  // Request latched on acceptance
  always_ff @(posedge clk_i) begin
    if (rd_en_o) begin
      op_q    <= req_op_i;
      index_q <= req_index_i;
      tag_q   <= req_tag_i;
      dirty_q <= req_dirty_i;
      way_q   <= req_way_i;
    end
  end

  // --------------------------------------------------------------------------
  // Response and write-back
  // --------------------------------------------------------------------------

  always_comb begin : proc_response
    rsp_way_o       = '0;
    rsp_hit_o       = 1'b0;
    rsp_evict_o     = 1'b0;
    rsp_evict_tag_o = '0;
    wr_en_o         = 1'b0;
    wr_way_o        = '0;
    wr_tag_o        = '0;
    wr_valid_o      = 1'b0;
    wr_dirty_o      = 1'b0;
    take_o          = 1'b0;
    if (state_q == RESPOND) begin
      if (op_q == OP_FLUSH) begin
        rsp_way_o       = way_q;
        rsp_evict_o     = flush_evict;
        rsp_evict_tag_o = flush_tag;
        // Clear the entry once the response is taken
        if (rsp_fire) begin
          wr_en_o  = 1'b1;
          wr_way_o = way_q;
        end
      end else if (is_hit) begin
        rsp_way_o = hit_vec;
        rsp_hit_o = 1'b1;
        // Promote a clean line to dirty
        if (rsp_fire && dirty_q && !hit_dirty) begin
          wr_en_o    = 1'b1;
          wr_way_o   = hit_vec;
          wr_tag_o   = tag_q;
          wr_valid_o = 1'b1;
          wr_dirty_o = 1'b1;
        end
      end else begin
        rsp_way_o       = victim_i;
        rsp_evict_o     = victim_evict_i;
        rsp_evict_tag_o = victim_tag_i;
        // Fill the victim, nothing to do if all ways are locked
        if (rsp_fire && (|victim_i)) begin
          wr_en_o    = 1'b1;
          wr_way_o   = victim_i;
          wr_tag_o   = tag_q;
          wr_valid_o = 1'b1;
          wr_dirty_o = dirty_q;
          take_o     = 1'b1;
        end
      end
    end
  end

endmodule

// ==== hdl/tag_way_array.sv ====
`timescale 1ns/1ps

module tag_way_array (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  logic                                                rd_en_i,
  input  logic                                                wr_en_i,
  input  llc_tag_pkg::way_ind_t                               wr_way_i,
  input  llc_tag_pkg::index_t                                 index_i,
  input  llc_tag_pkg::tag_t                                   cmp_tag_i,
  input  llc_tag_pkg::tag_t                                   wr_tag_i,
  input  logic                                                wr_valid_i,
  input  logic                                                wr_dirty_i,
  output llc_tag_pkg::way_ind_t                               valid_o,
  output llc_tag_pkg::way_ind_t                               dirty_o,
  output llc_tag_pkg::way_ind_t                               match_o,
  output llc_tag_pkg::tag_t [llc_tag_pkg::NUM_WAYS-1:0]       tags_o
);

  import llc_tag_pkg::*;

  // Compare tag captured together with the read
  tag_t cmp_tag_q;

  always_ff @(posedge clk_i) begin
    if (rd_en_i) begin
      cmp_tag_q <= cmp_tag_i;
    end
  end

  // --------------------------------------------------------------------------
  // One storage slice per way
  // --------------------------------------------------------------------------

  for (genvar w = 0; w < NUM_WAYS; w++) begin : gen_way
    // Tag memory and dirty bits
    tag_t                tag_mem [NUM_SETS];
    logic [NUM_SETS-1:0] dirty_mem;
    // Valid bits, cleared on reset so every set starts empty
    logic [NUM_SETS-1:0] valid_mem;
    // Read data registers
    logic                valid_q;
    logic                dirty_q;
    tag_t                tag_q;
    logic                wr_here;

    // Write strobe for this way only
    assign wr_here = wr_en_i & wr_way_i[w];

    // Tag and dirty storage
    always_ff @(posedge clk_i) begin
      if (wr_here) begin
        tag_mem[index_i]   <= wr_tag_i;
        dirty_mem[index_i] <= wr_dirty_i;
      end
    end

    // Valid storage
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        valid_mem <= '0;
      end else if (wr_here) begin
        valid_mem[index_i] <= wr_valid_i;
      end
    end

    // Read port, one cycle latency
    // Outputs hold their value until the next read
    always_ff @(posedge clk_i) begin
      if (reset_i) begin
        valid_q <= 1'b0;
      end else if (rd_en_i) begin
        valid_q <= valid_mem[index_i];
      end
    end

    always_ff @(posedge clk_i) begin
      if (rd_en_i) begin
        dirty_q <= dirty_mem[index_i];
        tag_q   <= tag_mem[index_i];
      end
    end

    assign valid_o[w] = valid_q;
    assign dirty_o[w] = dirty_q;
    assign tags_o[w]  = tag_q;

    // Tag compare on the registered values
    // Valid and lock qualification happen in the controller
    assign match_o[w] = (tag_q == cmp_tag_q);
  end

endmodule

// ==== hdl/victim_picker.sv ====
`timescale 1ns/1ps

module victim_picker (
  input  logic                                                clk_i,
  input  logic                                                reset_i,
  input  llc_tag_pkg::way_ind_t                               valid_i,
  input  llc_tag_pkg::way_ind_t                               dirty_i,
  input  llc_tag_pkg::way_ind_t                               lock_i,
  input  llc_tag_pkg::tag_t [llc_tag_pkg::NUM_WAYS-1:0]       tags_i,
  input  logic                                                take_i,
  output llc_tag_pkg::way_ind_t                               victim_o,
  output logic                                                evict_o,
  output llc_tag_pkg::tag_t                                   evict_tag_o
);

  import llc_tag_pkg::*;

  // Round-robin pointer over the ways
  way_sel_t ptr_q;

  way_ind_t free_ways;
  way_ind_t usable_ways;
  way_sel_t victim_sel;
  logic     found;
  logic     from_ptr;

  // Invalid and unlocked ways can be filled without eviction
  assign free_ways   = ~valid_i & ~lock_i;
  assign usable_ways = ~lock_i;

  // --------------------------------------------------------------------------
  // Victim selection
  // --------------------------------------------------------------------------

  always_comb begin : proc_pick
    way_sel_t idx;
    idx        = '0;
    victim_sel = '0;
    found      = 1'b0;
    from_ptr   = 1'b0;
    // Lowest free way wins, so scan downwards
    for (int i = NUM_WAYS - 1; i >= 0; i--) begin
      if (free_ways[i]) begin
        victim_sel = way_sel_t'(i);
        found      = 1'b1;
      end
    end
    // All unlocked ways valid
    // First unlocked way at or after the pointer, scan downwards again
    if (!found) begin
      for (int i = NUM_WAYS - 1; i >= 0; i--) begin
        idx = ptr_q + way_sel_t'(i);
        if (usable_ways[idx]) begin
          victim_sel = idx;
          found      = 1'b1;
          from_ptr   = 1'b1;
        end
      end
    end
  end

  // Zero victim when every way is locked
  assign victim_o    = found ? (way_ind_t'(1) << victim_sel) : '0;
  // Only a replaced valid line can need a write-back
  assign evict_o     = from_ptr & dirty_i[victim_sel];
  assign evict_tag_o = from_ptr ? tags_i[victim_sel] : '0;

  // Pointer moves past the replaced way, only for round-robin choices
  always_ff @(posedge clk_i) begin
    if (reset_i) begin
      ptr_q <= '0;
    end else if (take_i && from_ptr) begin
      ptr_q <= victim_sel + way_sel_t'(1);
    end
  end

endmodule

// ==== testbench/tb_llc_tag_store.sv ====
`timescale 1ns/1ps

module tb_llc_tag_store;

  import llc_tag_pkg::*;

  localparam int CLK_PERIOD   = 40;
  localparam int RESET_CYCLES = 8;
  // Upper bound on the directed requests below
  localparam int NUM_DIRECTED = 20;
  localparam int NUM_RANDOM   = 200;
  localparam int WATCHDOG_NS  =
    (NUM_DIRECTED + NUM_RANDOM) * 10 * CLK_PERIOD + (RESET_CYCLES + 2) * CLK_PERIOD;

  logic     clk_i;
  logic     reset_i;
  logic     req_valid_i;
  logic     req_ready_o;
  tag_op_e  req_op_i;
  index_t   req_index_i;
  tag_t     req_tag_i;
  logic     req_dirty_i;
  way_ind_t req_way_i;
  way_ind_t spm_lock_i;
  logic     rsp_valid_o;
  logic     rsp_ready_i;
  way_ind_t rsp_way_o;
  logic     rsp_hit_o;
  logic     rsp_evict_o;
  tag_t     rsp_evict_tag_o;

  integer seed = 42858;
  string  test_name = "reset";

  // Reference state per set and way
  tag_t m_tag     [NUM_SETS][NUM_WAYS];
  logic m_valid   [NUM_SETS][NUM_WAYS];
  logic m_dirty   [NUM_SETS][NUM_WAYS];
  // Tag known to the model, flush of an unknown entry is skipped
  logic m_written [NUM_SETS][NUM_WAYS];
  int   m_ptr;

  // Request as seen on the accepting edge
  tag_op_e  acc_op;
  index_t   acc_index;
  tag_t     acc_tag;
  logic     acc_dirty;
  way_ind_t acc_way;
  logic [15:0] exp_rsp;

  llc_tag_store u_dut (
    .clk_i           (clk_i),
    .reset_i         (reset_i),
    .req_valid_i     (req_valid_i),
    .req_ready_o     (req_ready_o),
    .req_op_i        (req_op_i),
    .req_index_i     (req_index_i),
    .req_tag_i       (req_tag_i),
    .req_dirty_i     (req_dirty_i),
    .req_way_i       (req_way_i),
    .spm_lock_i      (spm_lock_i),
    .rsp_valid_o     (rsp_valid_o),
    .rsp_ready_i     (rsp_ready_i),
    .rsp_way_o       (rsp_way_o),
    .rsp_hit_o       (rsp_hit_o),
    .rsp_evict_o     (rsp_evict_o),
    .rsp_evict_tag_o (rsp_evict_tag_o)
  );

  initial begin
    clk_i = 1'b0;
    forever #(CLK_PERIOD / 2) clk_i = ~clk_i;
  end

  // --------------------------------------------------------------------------
  // Reference model and compare
  // --------------------------------------------------------------------------

  // Returns {way, hit, evict, evict tag} and advances the model state
  function automatic logic [15:0] model_step(input tag_op_e op, input index_t idx,
                                             input tag_t tag, input logic dirty,
                                             input way_ind_t way, input way_ind_t lock);
    way_ind_t e_way;
    logic     e_hit;
    logic     e_evict;
    tag_t     e_tag;
    int       sel;
    int       p;
    logic     from_ptr;
    e_way    = '0;
    e_hit    = 1'b0;
    e_evict  = 1'b0;
    e_tag    = '0;
    sel      = -1;
    from_ptr = 1'b0;
    if (op == OP_FLUSH) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (way[w]) sel = w;
      end
      e_way = way;
      if (sel >= 0) begin
        e_evict = m_valid[idx][sel] & m_dirty[idx][sel];
        e_tag   = m_tag[idx][sel];
        m_tag[idx][sel]   = '0;
        m_valid[idx][sel] = 1'b0;
        m_dirty[idx][sel] = 1'b0;
      end
    end else begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        if (!lock[w] && m_valid[idx][w] && (m_tag[idx][w] == tag)) sel = w;
      end
      if (sel >= 0) begin
        e_way = way_ind_t'(1) << sel;
        e_hit = 1'b1;
        if (dirty) m_dirty[idx][sel] = 1'b1;
      end else begin
        // Lowest invalid unlocked way first
        for (int w = NUM_WAYS - 1; w >= 0; w--) begin
          if (!lock[w] && !m_valid[idx][w]) sel = w;
        end
        // Else round robin from the pointer
        if (sel < 0) begin
          for (int k = 0; k < NUM_WAYS; k++) begin
            p = (m_ptr + k) % NUM_WAYS;
            if (sel < 0 && !lock[p]) begin
              sel      = p;
              from_ptr = 1'b1;
            end
          end
        end
        if (sel >= 0) begin
          e_way = way_ind_t'(1) << sel;
          if (from_ptr) begin
            e_evict = m_dirty[idx][sel];
            e_tag   = m_tag[idx][sel];
            m_ptr   = (sel + 1) % NUM_WAYS;
          end
          m_tag[idx][sel]     = tag;
          m_valid[idx][sel]   = 1'b1;
          m_dirty[idx][sel]   = dirty;
          m_written[idx][sel] = 1'b1;
        end
      end
    end
    return {e_way, e_hit, e_evict, e_tag};
  endfunction

  task automatic check(input string what, input logic [31:0] expected,
                       input logic [31:0] actual);
    if (actual !== expected) begin
      $display("[ERROR] %s %s: expected 0x%0h, actual 0x%0h",
               test_name, what, expected, actual);
      $display("ERRORS FOUND");
      $fatal(1, "Stopped at the first mismatch");
    end
  endtask

  // Sampled mid cycle, the handshake follows on the next rising edge
  always @(negedge clk_i) begin
    if (!reset_i) begin
      if (req_valid_i && req_ready_o) begin
        acc_op    <= req_op_i;
        acc_index <= req_index_i;
        acc_tag   <= req_tag_i;
        acc_dirty <= req_dirty_i;
        acc_way   <= req_way_i;
      end
      if (rsp_valid_o && rsp_ready_i) begin
        exp_rsp = model_step(acc_op, acc_index, acc_tag, acc_dirty, acc_way, spm_lock_i);
        check("rsp_way_o", 32'(exp_rsp[15:12]), 32'(rsp_way_o));
        check("rsp_hit_o", 32'(exp_rsp[11]), 32'(rsp_hit_o));
        check("rsp_evict_o", 32'(exp_rsp[10]), 32'(rsp_evict_o));
        check("rsp_evict_tag_o", 32'(exp_rsp[9:0]), 32'(rsp_evict_tag_o));
      end
    end
  end

  // --------------------------------------------------------------------------
  // Stimulus
  // --------------------------------------------------------------------------

  // Entered and left on a rising edge
  task automatic run_request(input tag_op_e op, input index_t idx, input tag_t tag,
                             input logic dirty, input way_ind_t way, input way_ind_t lock);
    logic [31:0] r;
    req_valid_i <= 1'b1;
    req_op_i    <= op;
    req_index_i <= idx;
    req_tag_i   <= tag;
    req_dirty_i <= dirty;
    req_way_i   <= way;
    // Lock level held until the response is taken
    spm_lock_i  <= lock;
    do @(negedge clk_i); while (!req_ready_o);
    @(posedge clk_i);
    req_valid_i <= 1'b0;
    // Back-pressure of 0 to 3 cycles
    r = $random(seed);
    repeat (r[1:0]) @(posedge clk_i);
    rsp_ready_i <= 1'b1;
    do @(negedge clk_i); while (!rsp_valid_o);
    @(posedge clk_i);
    rsp_ready_i <= 1'b0;
  endtask

  initial begin
    logic [31:0] r;
    index_t      idx;
    tag_t        tag;
    reset_i     = 1'b1;
    req_valid_i = 1'b0;
    req_op_i    = OP_LOOKUP;
    req_index_i = '0;
    req_tag_i   = '0;
    req_dirty_i = 1'b0;
    req_way_i   = '0;
    spm_lock_i  = '0;
    rsp_ready_i = 1'b0;
    m_ptr       = 0;
    for (int s = 0; s < NUM_SETS; s++) begin
      for (int w = 0; w < NUM_WAYS; w++) begin
        m_tag[s][w]     = '0;
        m_valid[s][w]   = 1'b0;
        m_dirty[s][w]   = 1'b0;
        m_written[s][w] = 1'b0;
      end
    end
    repeat (RESET_CYCLES) @(posedge clk_i);
    reset_i <= 1'b0;
    @(negedge clk_i);
    check("req_ready_o", 32'd1, 32'(req_ready_o));
    check("rsp_valid_o", 32'd0, 32'(rsp_valid_o));
    @(posedge clk_i);
    run_request(OP_LOOKUP, 6'd0, 10'h011, 1'b0, '0, '0);
    // Fill lowest first, then hits with a dirty promotion
    test_name = "fill";
    run_request(OP_LOOKUP, 6'd0, 10'h012, 1'b1, '0, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h013, 1'b0, '0, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h014, 1'b0, '0, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h013, 1'b0, '0, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h011, 1'b1, '0, '0);
    test_name = "round_robin";
    run_request(OP_LOOKUP, 6'd0, 10'h021, 1'b0, '0, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h022, 1'b0, '0, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h023, 1'b1, '0, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h024, 1'b0, '0, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h025, 1'b0, '0, '0);
    test_name = "flush";
    run_request(OP_FLUSH, 6'd0, 10'h000, 1'b0, 4'b0100, '0);
    run_request(OP_LOOKUP, 6'd0, 10'h023, 1'b0, '0, '0);
    test_name = "lock";
    // Valid matching line in a locked way, all ways locked
    run_request(OP_LOOKUP, 6'd0, 10'h023, 1'b1, '0, 4'b1111);
    for (int n = 0; n < 5; n++) begin
      run_request(OP_LOOKUP, 6'd6, tag_t'(10'h040 + n), 1'b1, '0, 4'b0001);
    end
    // Small tag pool over four sets, way 2 of set 3 locked
    test_name = "random";
    for (int n = 0; n < NUM_RANDOM; n++) begin
      r   = $random(seed);
      idx = index_t'(r[1:0]);
      tag = {7'b0100000, r[4:2]};
      if (r[9:8] == 2'b00 && m_written[idx][r[7:6]]) begin
        run_request(OP_FLUSH, idx, tag, r[5], 4'b0001 << r[7:6],
                    (idx == 6'd3) ? 4'b0100 : 4'b0000);
      end else begin
        run_request(OP_LOOKUP, idx, tag, r[5], '0, (idx == 6'd3) ? 4'b0100 : 4'b0000);
      end
    end
    test_name = "end";
    // Ready again in the cycle after the last handshake
    @(negedge clk_i);
    check("req_ready_o", 32'd1, 32'(req_ready_o));
    check("rsp_valid_o", 32'd0, 32'(rsp_valid_o));
    $display("NO ERRORS");
    $finish;
  end

  // Watchdog sized from the request count
  initial begin
    #(WATCHDOG_NS);
    $display("Timeout, the DUT did not finish all requests in time");
    $display("ERRORS FOUND");
    $fatal(1, "Watchdog expired");
  end

endmodule

// ==== testbench/tb_llc_tag_store_asserts.sv ====
`timescale 1ns/1ps

module llc_tag_store_asserts (
  input  logic                  clk_i,
  input  logic                  reset_i,
  input  logic                  req_ready_o,
  input  logic                  rsp_valid_o,
  input  logic                  rsp_ready_i,
  input  llc_tag_pkg::way_ind_t rsp_way_o,
  input  logic                  rsp_hit_o,
  input  logic                  rsp_evict_o,
  input  llc_tag_pkg::tag_t     rsp_evict_tag_o
);

  import llc_tag_pkg::*;

  // --------------------------------------------------------------------------
  // Response handshake
  // --------------------------------------------------------------------------

  // Pending response holds with all its fields until taken
  assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o && !rsp_ready_i |=> rsp_valid_o && $stable(rsp_way_o) &&
      $stable(rsp_hit_o) && $stable(rsp_evict_o) && $stable(rsp_evict_tag_o))
  else $error("Response dropped or changed before rsp_ready_i");

  // One request in flight, no new accept during a response
  assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o |-> !req_ready_o)
  else $error("req_ready_o high while a response is pending");

  // Way at most one-hot, and a hit always names its way
  assert property (@(posedge clk_i) disable iff (reset_i)
    rsp_valid_o |-> $onehot0(rsp_way_o) && (!rsp_hit_o || (rsp_way_o != '0)))
  else $error("rsp_way_o is not one-hot or empty on a hit");

endmodule

bind llc_tag_store llc_tag_store_asserts u_asserts (
  .clk_i           (clk_i),
  .reset_i         (reset_i),
  .req_ready_o     (req_ready_o),
  .rsp_valid_o     (rsp_valid_o),
  .rsp_ready_i     (rsp_ready_i),
  .rsp_way_o       (rsp_way_o),
  .rsp_hit_o       (rsp_hit_o),
  .rsp_evict_o     (rsp_evict_o),
  .rsp_evict_tag_o (rsp_evict_tag_o)
);
